// ==== exec_trace.txt ====
# instr pc rs1data rs2data alu_out (hex words), then jump, rdsel (hex), reg_write, illegal
# lines starting with # are skipped
002081b3 00000000 00000005 00000007 0000000c 0 03 1 0
402081b3 00000004 00000005 00000007 fffffffe 0 03 1 0
002091b3 00000008 00000001 00000024 00000010 0 03 1 0
0020a1b3 0000000c ffffffff 00000001 00000001 0 03 1 0
0020b1b3 00000010 ffffffff 00000001 00000000 0 03 1 0
0020c1b3 00000014 f0f0f0f0 0ff00ff0 ff00ff00 0 03 1 0
0020d1b3 00000018 80000000 00000004 08000000 0 03 1 0
4020d1b3 0000001c 80000000 00000004 f8000000 0 03 1 0
0020e1b3 00000020 12340000 00005678 12345678 0 03 1 0
0020f1b3 00000024 ffff0000 12345678 12340000 0 03 1 0
fff08293 00000028 00000010 deadbeef 0000000f 0 05 1 0
fff0a293 0000002c 00000005 00000000 00000000 0 05 1 0
fff0b293 00000030 00000005 00000000 00000001 0 05 1 0
4030d293 00000034 ffffff00 00000000 ffffffe0 0 05 1 0
123453b7 00000038 00000000 00000000 12345000 0 07 1 0
00001397 00000100 00000000 00000000 00001100 0 07 1 0
010000ef 00000200 00000000 00000000 00000210 1 01 1 0
ff9ff06f 00000300 00000000 00000000 000002f8 1 00 1 0
004280e7 00000304 00001001 00000000 00001005 1 01 1 0
00208463 00000400 00000055 00000055 00000408 1 00 0 0
00209463 00000404 00000055 00000055 0000040c 0 00 0 0
0020c463 00000408 ffffffff 00000001 00000410 1 00 0 0
0020d463 0000040c fffffff0 00000005 00000414 0 00 0 0
0020e463 00000410 ffffffff 00000001 00000418 0 00 0 0
0020f463 00000414 00000007 00000007 0000041c 1 00 0 0
fe20c8e3 00000500 00000003 00000002 000004f0 0 00 0 0
0020a463 00000418 00000001 00000001 00000420 0 00 0 0
00c0a303 00000600 00002000 00000000 0000200c 0 06 1 0
0020a423 00000604 00003000 11223344 00003008 0 00 0 0
fe20a623 00000608 00003000 55667788 00002fec 0 00 0 0
ffffffff 00000700 00000001 00000002 00000000 0 00 0 1

// ==== files.f ====
core_pkg.sv
exec_alu.sv
branch_comp.sv
rv_decoder.sv
execute_stage.sv
exec_top.sv
exec_assert.sv
tb_exec.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module tb_exec

run: build
	./obj_dir/Vtb_exec | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module exec_top

clean:
	rm -rf obj_dir sim.log

// ==== tb_exec.sv ====
// Trace-driven testbench for exec_top
// Reads exec_trace.txt from the working directory, one instruction per line
// Idle gaps of 0 to 3 cycles between strobes; the last eight strobes are back to back
module tb_exec;
    import core_pkg::*;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] alu_out;
        logic        jump;
        logic [4:0]  rdsel;
        logic        reg_write;
        logic        illegal;
    } trace_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    instr_u      instr;
    logic [31:0] pc;
    logic [31:0] rs1data;
    logic [31:0] rs2data;
    ex_result_t  result;
    logic        out_valid;

    trace_t      items[$];    // Whole trace
    trace_t      pending[$];  // Driven, not yet checked
    ex_result_t  held;        // Last latched value seen
    logic [31:0] rng;         // Gap generator state
    int          pulses;      // out_valid pulses seen

    exec_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .pc        (pc),
        .rs1data   (rs1data),
        .rs2data   (rs2data),
        .result    (result),
        .out_valid (out_valid)
    );

    always #5 clk = ~clk;

    // Counts every result pulse, apart from the checker
    always @(negedge clk) begin
        if (out_valid)
            pulses++;
    end

    ////////////////////
    // Helpers
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic expect_equal(input string field, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got == exp) else begin
            fail_run($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                               $time, field, got, exp));
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f[9];
        trace_t      t;
        fd = $fopen("exec_trace.txt", "r");
        if (fd == 0)
            fail_run("could not open exec_trace.txt");
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;  // Comment or blank
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (cnt != 9)
                fail_run($sformatf("malformed trace line: %s", line));
            t.instr     = f[0];
            t.pc        = f[1];
            t.rs1       = f[2];
            t.rs2       = f[3];
            t.alu_out   = f[4];
            t.jump      = f[5][0];
            t.rdsel     = f[6][4:0];
            t.reg_write = f[7][0];
            t.illegal   = f[8][0];
            items.push_back(t);
        end
        $fclose(fd);
    endtask

    task automatic drive_item(input trace_t t);
        in_valid = 1'b1;
        instr    = t.instr;
        pc       = t.pc;
        rs1data  = t.rs1;
        rs2data  = t.rs2;
    endtask

    task automatic drive_idle();
        in_valid = 1'b0;
        instr    = 32'hffff_ffff;  // Junk word, must not reach the latch
    endtask

    // Latch must hold while no result is due
    task automatic wait_for_result();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (!out_valid) begin
                assert (result == held) else
                    fail_run("latched result changed without a strobe");
            end
        end while (!out_valid && cycles < 20);
        if (!out_valid)
            fail_run("no result arrived from the DUT within 20 cycles");
        if (pending.size() == 0)
            fail_run("DUT gave a result with no instruction pending");
    endtask

    task automatic check_result(input trace_t t);
        expect_equal("next_pc", result.next_pc, t.pc + 32'd4);
        expect_equal("alu_out", result.alu_out, t.alu_out);
        expect_equal("rs2data", result.rs2data, t.rs2);
        expect_equal("jump", 32'(result.jump), 32'(t.jump));
        expect_equal("rdsel", 32'(result.rdsel), 32'(t.rdsel));
        expect_equal("reg_write", 32'(result.dec_op.reg_write), 32'(t.reg_write));
        expect_equal("illegal", 32'(result.dec_op.illegal), 32'(t.illegal));
        held = result;
    endtask

    ////////////////////
    // Main sequence
    initial begin
        int n;
        int gap;
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        pc       = '0;
        rs1data  = '0;
        rs2data  = '0;
        held     = '0;
        rng      = 32'h4162_0a40;
        pulses   = 0;
        load_trace();
        n = items.size();
        if (n == 0)
            fail_run("trace holds no instructions");
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            assert (!out_valid && result == '0) else
                fail_run("out_valid or result not cleared during reset");
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            begin  // Driver
                for (int i = 0; i < n; i++) begin
                    @(posedge clk);
                    #1;
                    drive_item(items[i]);
                    pending.push_back(items[i]);
                    rng = xorshift(rng);
                    gap = (i >= n - 8) ? 0 : int'(rng[1:0]);  // Burst at the end
                    for (int g = 0; g < gap; g++) begin
                        @(posedge clk);
                        #1;
                        drive_idle();
                    end
                end
                @(posedge clk);
                #1;
                drive_idle();
            end
            begin  // Checker, one pass per instruction
                for (int i = 0; i < n; i++) begin
                    wait_for_result();
                    check_result(pending.pop_front());
                end
            end
        join
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            assert (!out_valid) else
                fail_run("extra result after the last instruction");
        end
        if (pulses == n) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_run("number of results does not match the trace");
        end
    end

endmodule

// ==== exec_assert.sv ====
// Protocol checks for execute_stage, attached with bind
// Assumes one strobe per instruction and no stall path
module exec_assert (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic jump,
    input logic illegal
);

    // Result pulse exactly one clock after the strobe
    a_valid_delay: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid))
        else $error("out_valid does not follow in_valid by one cycle");

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high while reset is asserted");

    // Illegal ops never redirect the PC
    a_no_illegal_jump: assert property (@(posedge clk) disable iff (!rst_n)
        !(jump && illegal))
        else $error("jump set together with illegal");

endmodule

bind execute_stage exec_assert exec_assert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .jump      (result.jump),
    .illegal   (result.dec_op.illegal)
);

// ==== exec_top.sv ====
// Decode plus execute, one clock from strobe to latched result
// Register values come from outside; a strobe may arrive every cycle
module exec_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  core_pkg::instr_u          instr,
    input  logic [core_pkg::xlen-1:0] pc,
    input  logic [core_pkg::xlen-1:0] rs1data,
    input  logic [core_pkg::xlen-1:0] rs2data,
    output core_pkg::ex_result_t      result,
    output logic                      out_valid
);
    import core_pkg::*;

    dec_bundle_t bundle;     // Decoder to execute
    logic        dec_valid;  // Same cycle as in_valid

    rv_decoder u_dec (
        .instr     (instr),
        .pc        (pc),
        .rs1data   (rs1data),
        .rs2data   (rs2data),
        .in_valid  (in_valid),
        .bundle    (bundle),
        .dec_valid (dec_valid)
    );

    execute_stage u_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (dec_valid),
        .bundle    (bundle),
        .result    (result),
        .out_valid (out_valid)
    );

endmodule

// ==== execute_stage.sv ====
// Execute stage: operand select, ALU, jump decision, latch toward memory
// Always completes in one clock; no stall and no back-pressure
// Result holds its value between strobes
module execute_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  core_pkg::dec_bundle_t bundle,
    output core_pkg::ex_result_t  result,
    output logic                  out_valid
);
    import core_pkg::*;

    logic [xlen-1:0] alu_in1;
    logic [xlen-1:0] alu_in2;
    logic [xlen-1:0] alu_res;
    logic            jump;
    ex_result_t      res_d;  // Next latch value

    ////////////////////
    // Operand select
    assign alu_in1 = bundle.dec_op.use_rs1 ? bundle.rs1data : bundle.curr_pc;
    assign alu_in2 = bundle.dec_op.use_rs2 ? bundle.rs2data : bundle.imm;

    exec_alu u_alu (
        .alu_in1   (alu_in1),
        .alu_in2   (alu_in2),
        .funct_alu (bundle.funct_alu),
        .alu_out   (alu_res)
    );

    branch_comp u_comp (
        .rs1data (bundle.rs1data),
        .rs2data (bundle.rs2data),
        .dec_op  (bundle.dec_op),
        .jump    (jump)
    );

    // Illegal op carries no ALU value downstream
    assign res_d = '{
        next_pc: bundle.next_pc,
        alu_out: bundle.dec_op.illegal ? {xlen{1'b0}} : alu_res,
        rs2data: bundle.rs2data,     // Store data
        jump:    jump,
        dec_op:  bundle.dec_op,
        rdsel:   bundle.rdsel
    };

    ////////////////////
    // Latch for the memory stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            result <= '0;
        else if (in_valid)
            result <= res_d;  // Hold otherwise
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= in_valid;  // One pulse per accepted instr
    end

endmodule

// ==== rv_decoder.sv ====
// Combinational RV32I decoder for the execute path
// Only the opcode is checked for legality; funct7 bits other than bit 5 are ignored
// rdsel is zero whenever the instruction writes no register
module rv_decoder (
    input  core_pkg::instr_u            instr,
    input  logic [core_pkg::xlen-1:0]   pc,
    input  logic [core_pkg::xlen-1:0]   rs1data,
    input  logic [core_pkg::xlen-1:0]   rs2data,
    input  logic                        in_valid,
    output core_pkg::dec_bundle_t       bundle,
    output logic                        dec_valid
);
    import core_pkg::*;

    dec_op_t           op;
    logic [xlen-1:0]   imm;
    alu_func_t         func;
    logic [rsel_w-1:0] rd;
    logic [xlen-1:0]   imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [19:0]       u_hi;  // Upper 20 bits, shared by U and J

    // OP and OP-IMM share one funct3 table; SUB only exists for OP
    function automatic alu_func_t arith_func(input logic [2:0] f3, input logic alt,
                                             input logic sub_ok);
        alu_func_t f;
        case (f3)
            F3_ADD_SUB: f = (alt && sub_ok) ? ALU_SUB : ALU_ADD;
            F3_SLL:     f = ALU_SLL;
            F3_SLT:     f = ALU_SLT;
            F3_SLTU:    f = ALU_SLTU;
            F3_XOR:     f = ALU_XOR;
            F3_SRL_SRA: f = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      f = ALU_OR;
            F3_AND:     f = ALU_AND;
            default:    f = ALU_ADD;
        endcase
        return f;
    endfunction

    ////////////////////
    // Immediates, one per format
    assign u_hi  = instr.u_fmt.imm_31_12;
    assign imm_i = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
    assign imm_s = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
    assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {u_hi, 12'h000};
    // J-type: imm[20|10:1|11|19:12] sits in instr[31:12]
    assign imm_j = {{11{u_hi[19]}}, u_hi[19], u_hi[7:0], u_hi[8], u_hi[18:9], 1'b0};

    ////////////////////
    // Control decode
    always_comb begin
        op   = '0;       // Everything off unless the opcode says otherwise
        imm  = '0;
        func = ALU_ADD;  // Address sums for jumps, branches, loads, stores
        rd   = '0;
        case (instr.r_fmt.opcode)
            OPC_OP: begin
                op.use_rs1   = 1'b1;
                op.use_rs2   = 1'b1;
                op.reg_write = 1'b1;
                func = arith_func(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b1);
            end
            OPC_OP_IMM: begin
                op.use_rs1   = 1'b1;
                op.reg_write = 1'b1;
                imm  = imm_i;  // Shift amount in imm[4:0]
                func = arith_func(instr.r_fmt.funct3, instr.r_fmt.funct7[5], 1'b0);
            end
            OPC_LUI: begin
                op.reg_write = 1'b1;
                imm  = imm_u;
                func = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                op.reg_write = 1'b1;
                imm = imm_u;  // PC + imm
            end
            OPC_JAL: begin
                op.is_jal    = 1'b1;
                op.reg_write = 1'b1;
                imm = imm_j;
            end
            OPC_JALR: begin
                op.use_rs1   = 1'b1;
                op.is_jalr   = 1'b1;
                op.reg_write = 1'b1;
                imm = imm_i;  // Bit 0 left as is
            end
            OPC_BRANCH: begin
                op.is_branch = 1'b1;
                imm = imm_b;  // Target from PC, compare done apart
            end
            OPC_LOAD: begin
                op.use_rs1   = 1'b1;
                op.is_load   = 1'b1;
                op.reg_write = 1'b1;
                imm = imm_i;
            end
            OPC_STORE: begin
                op.use_rs1  = 1'b1;
                op.is_store = 1'b1;
                imm = imm_s;
            end
            default: op.illegal = 1'b1;
        endcase
        if (!op.illegal)
            op.funct3 = instr.r_fmt.funct3;
        if (op.reg_write)
            rd = instr.r_fmt.rd;
    end

    assign bundle = '{
        dec_op:    op,
        imm:       imm,
        rs1data:   rs1data,
        rs2data:   rs2data,
        curr_pc:   pc,
        next_pc:   pc + xlen'(4),  // Sequential PC
        funct_alu: func,
        rdsel:     rd
    };

    assign dec_valid = in_valid;  // Decode takes no cycle

endmodule

// ==== branch_comp.sv ====
// Jump decision for the execute stage, combinational
// JAL and JALR always jump; branches compare the raw register values
// Reserved branch funct3 codes 2 and 3 never jump
module branch_comp (
    input  logic [core_pkg::xlen-1:0] rs1data,
    input  logic [core_pkg::xlen-1:0] rs2data,
    input  core_pkg::dec_op_t         dec_op,
    output logic                      jump
);
    import core_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    // One comparator set serves all six branches
    assign eq   = rs1data == rs2data;
    assign lt_s = $signed(rs1data) < $signed(rs2data);
    assign lt_u = rs1data < rs2data;

    always_comb begin
        jump = 1'b0;
        if (dec_op.is_jal || dec_op.is_jalr) begin
            jump = 1'b1;  // Unconditional
        end else if (dec_op.is_branch) begin
            case (dec_op.funct3)
                F3_BEQ:  jump = eq;
                F3_BNE:  jump = !eq;
                F3_BLT:  jump = lt_s;
                F3_BGE:  jump = !lt_s;
                F3_BLTU: jump = lt_u;
                F3_BGEU: jump = !lt_u;
                default: jump = 1'b0;  // Reserved
            endcase
        end
    end

endmodule

// ==== exec_alu.sv ====
// RV32I integer ALU, purely combinational
// Shifts use only alu_in2[4:0]; unknown function codes give zero
module exec_alu (
    input  logic [core_pkg::xlen-1:0] alu_in1,
    input  logic [core_pkg::xlen-1:0] alu_in2,
    input  core_pkg::alu_func_t       funct_alu,
    output logic [core_pkg::xlen-1:0] alu_out
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = alu_in2[4:0];
    assign lt_s  = $signed(alu_in1) < $signed(alu_in2);
    assign lt_u  = alu_in1 < alu_in2;

    always_comb begin
        case (funct_alu)
            ALU_ADD:
                alu_out = alu_in1 + alu_in2;
            ALU_SUB:
                alu_out = alu_in1 - alu_in2;
            ALU_SLL:
                alu_out = alu_in1 << shamt;
            ALU_SLT:
                alu_out = {{(xlen-1){1'b0}}, lt_s};  // Zero-extended flag
            ALU_SLTU:
                alu_out = {{(xlen-1){1'b0}}, lt_u};
            ALU_XOR:
                alu_out = alu_in1 ^ alu_in2;
            ALU_SRL:
                alu_out = alu_in1 >> shamt;
            ALU_SRA:
                alu_out = $unsigned($signed(alu_in1) >>> shamt);  // Sign fill
            ALU_OR:
                alu_out = alu_in1 | alu_in2;
            ALU_AND:
                alu_out = alu_in1 & alu_in2;
            ALU_PASS_B:
                alu_out = alu_in2;  // LUI
            default:
                alu_out = '0;
        endcase
    end

endmodule

// ==== core_pkg.sv ====
// Shared widths, encodings and stage types for the RV32I decode/execute path
// Only the base integer groups are encoded; no CSR, FENCE or system opcodes
// Stage structs are packed so a whole stage latch is one register
package core_pkg;

    localparam int xlen   = 32;  // Data word width
    localparam int rsel_w = 5;   // Register index width

    ////////////////////
    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'd0;
    localparam logic [2:0] F3_SLL     = 3'd1;
    localparam logic [2:0] F3_SLT     = 3'd2;
    localparam logic [2:0] F3_SLTU    = 3'd3;
    localparam logic [2:0] F3_XOR     = 3'd4;
    localparam logic [2:0] F3_SRL_SRA = 3'd5;  // funct7[5] picks SRA
    localparam logic [2:0] F3_OR      = 3'd6;
    localparam logic [2:0] F3_AND     = 3'd7;

    // funct3 of BRANCH, codes 2 and 3 reserved
    localparam logic [2:0] F3_BEQ  = 3'd0;
    localparam logic [2:0] F3_BNE  = 3'd1;
    localparam logic [2:0] F3_BLT  = 3'd4;
    localparam logic [2:0] F3_BGE  = 3'd5;
    localparam logic [2:0] F3_BLTU = 3'd6;
    localparam logic [2:0] F3_BGEU = 3'd7;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_func_t;

    ////////////////////
    // Instruction formats, all 32 bits, MSB first
    typedef struct packed {
        logic [6:0] funct7; logic [rsel_w-1:0] rs2; logic [rsel_w-1:0] rs1;
        logic [2:0] funct3; logic [rsel_w-1:0] rd;  logic [6:0] opcode;
    } r_fmt_t;
    typedef struct packed {
        logic [11:0] imm_11_0; logic [rsel_w-1:0] rs1; logic [2:0] funct3;
        logic [rsel_w-1:0] rd; logic [6:0] opcode;
    } i_fmt_t;
    typedef struct packed {
        logic [6:0] imm_11_5; logic [rsel_w-1:0] rs2; logic [rsel_w-1:0] rs1;
        logic [2:0] funct3;   logic [4:0] imm_4_0;    logic [6:0] opcode;
    } s_fmt_t;
    typedef struct packed {
        logic imm_12; logic [5:0] imm_10_5; logic [rsel_w-1:0] rs2; logic [rsel_w-1:0] rs1;
        logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
    } b_fmt_t;
    typedef struct packed {
        logic [19:0] imm_31_12; logic [rsel_w-1:0] rd; logic [6:0] opcode;
    } u_fmt_t;  // J-type is reassembled from this view

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    ////////////////////
    // Stage payloads
    typedef struct packed {
        logic       use_rs1;    // ALU in1 is rs1data, else PC
        logic       use_rs2;    // ALU in2 is rs2data, else imm
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic       is_load;
        logic       is_store;
        logic       reg_write;
        logic       illegal;
        logic [2:0] funct3;
    } dec_op_t;  // 12 bits

    typedef struct packed {
        dec_op_t           dec_op;
        logic [xlen-1:0]   imm;
        logic [xlen-1:0]   rs1data;
        logic [xlen-1:0]   rs2data;
        logic [xlen-1:0]   curr_pc;
        logic [xlen-1:0]   next_pc;
        alu_func_t         funct_alu;
        logic [rsel_w-1:0] rdsel;
    } dec_bundle_t;

    typedef struct packed {
        logic [xlen-1:0]   next_pc;
        logic [xlen-1:0]   alu_out;
        logic [xlen-1:0]   rs2data;
        logic              jump;
        dec_op_t           dec_op;
        logic [rsel_w-1:0] rdsel;
    } ex_result_t;

endpackage
